//--- revo_encoder_sva.sv
`timescale 1ns/1ps
`default_nettype none

module revo_encoder_sva (
	input logic clock254,
	input logic reset,
	input logic raw_revo,
	input revo_pkg::revo_lines_t lines,
	input revo_pkg::revo_status_t status,
	input logic [7:0] leds
);

	int failures = 0;
	int high_run;
	logic [revo_pkg::quiet_samples-1:0] raw_hist;
	logic line_xor;
	logic qual_start;

	always_ff @(posedge clock254) begin
		if (reset) begin
			raw_hist <= '0;
		end else begin
			raw_hist <= {raw_hist[revo_pkg::quiet_samples-2:0], raw_revo};
		end
	end

	assign line_xor = lines.ref_line ^ lines.marked_line;
	// first high sample after a quiet window, once the link runs
	assign qual_start = raw_revo & (raw_hist == '0) & status.ready;

	// length of the current run of xor high samples
	always_ff @(posedge clock254) begin
		if (reset) begin
			high_run <= 0;
		end else if (line_xor) begin
			high_run <= high_run + 1;
		end else begin
			high_run <= 0;
		end
	end

	a_hold_quiet: assert property (@(posedge clock254) disable iff (reset)
		!status.ready |-> lines == '0)
		else begin
			$error("lines moved during the startup hold");
			failures = failures + 1;
		end

	a_ref_toggle: assert property (@(posedge clock254) disable iff (reset)
		$past(status.ready) |-> lines.ref_line != $past(lines.ref_line))
		else begin
			$error("reference line missed a toggle");
			failures = failures + 1;
		end

	// edge n on the raw input shows up on the lines at edge n+3
	a_marker_timing: assert property (@(posedge clock254) disable iff (reset)
		$rose(line_xor) == $past(qual_start, 4))
		else begin
			$error("line marker not aligned with a qualified raw edge");
			failures = failures + 1;
		end

	a_marker_width: assert property (@(posedge clock254) disable iff (reset)
		$fell(line_xor) |-> high_run == revo_pkg::quiet_samples)
		else begin
			$error("line marker width wrong, %0d cycles", high_run);
			failures = failures + 1;
		end

	a_revo_count: assert property (@(posedge clock254) disable iff (reset)
		$rose(status.marker) |=> status.revolutions == $past(status.revolutions) + 1'b1)
		else begin
			$error("revolution counter did not step on a recovered marker");
			failures = failures + 1;
		end

	a_leds: assert property (@(posedge clock254) disable iff (reset)
		!$past(reset) |-> leds == {~$past(status.ready), 2'b00, $past(status.marker),
			1'b0, $past(status.revolutions[0]), 1'b0, $past(status.ready)})
		else begin
			$error("led pattern does not match the status");
			failures = failures + 1;
		end

endmodule

bind revo_encoder_top revo_encoder_sva revo_encoder_sva_inst (
	.clock254(clock254),
	.reset(reset),
	.raw_revo(raw_revo),
	.lines(lines),
	.status(status),
	.leds(leds)
);

`default_nettype wire

//--- revo_encoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module revo_encoder_tb;

	localparam int quiet_gap = 32;
	localparam int settle_cycles = 20;
	localparam int random_markers = 8;
	// worst case with random gaps and lengths at their largest
	localparam int stimulus_cycles = 16 + quiet_gap
		+ 4 * (quiet_gap + 20 + settle_cycles)
		+ 3 * (quiet_gap + 5 + settle_cycles)
		+ random_markers * (51 + 8 + settle_cycles);
	localparam int cycle_limit = revo_pkg::hold_cycles + stimulus_cycles + 200;

	logic clock254;
	logic reset;
	logic raw_revo;
	revo_pkg::revo_lines_t lines;
	revo_pkg::revo_status_t status;
	logic [revo_pkg::led_count-1:0] leds;

	int cycle = 0;
	int seed;
	int value_errors;
	int release_cycle;
	int expected_revs;
	int expected_period;
	int last_start;
	bit have_last;
	bit period_known;

	revo_encoder_top revo_encoder_top_inst (
		.clock254(clock254),
		.reset(reset),
		.raw_revo(raw_revo),
		.lines(lines),
		.status(status),
		.leds(leds)
	);

	always #10 clock254 = ~clock254;

	always @(posedge clock254) begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("timeout: stimulus still running after %0d cycles", cycle);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			value_errors = value_errors + 1;
			$display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic wait_cycles(input int count);
		repeat (count) @(negedge clock254);
	endtask

	// expected count and period follow from the drive times
	task automatic note_marker(input int start);
		expected_revs = expected_revs + 1;
		if (have_last) begin
			expected_period = start - last_start;
			period_known = 1'b1;
		end
		have_last = 1'b1;
		last_start = start;
	endtask

	// first high sample is taken at the next rising edge
	task automatic send_pulse(input int quiet, input int len, input bit qualified);
		int start;
		wait_cycles(quiet);
		raw_revo = 1'b1;
		start = cycle + 1;
		wait_cycles(len);
		raw_revo = 1'b0;
		if (qualified) begin
			note_marker(start);
		end
	endtask

	task automatic check_status(input string name);
		wait_cycles(settle_cycles);
		check_value({name, " revolutions"}, expected_revs, int'(status.revolutions));
		if (period_known) begin
			check_value({name, " last_period"}, expected_period, int'(status.last_period));
		end else begin
			// no period before the second marker
			check_value({name, " last_period"}, 0, int'(status.last_period));
		end
	endtask

	initial begin
		int gap;
		int len;
		int sva_failures;
		clock254 = 1'b0;
		reset = 1'b1;
		raw_revo = 1'b0;
		seed = 32'h99c69614;
		value_errors = 0;
		expected_revs = 0;
		expected_period = 0;
		last_start = 0;
		have_last = 1'b0;
		period_known = 1'b0;

		repeat (16) @(posedge clock254);
		@(negedge clock254);
		reset = 1'b0;
		release_cycle = cycle;

		// this marker is still active as the hold ends and must not reach the lines
		send_pulse(revo_pkg::hold_cycles - 5, 4, 1'b0);
		while (!status.ready) begin
			@(negedge clock254);
		end
		check_value("hold length", revo_pkg::hold_cycles, cycle - release_cycle);
		wait_cycles(quiet_gap);
		check_value("hold marker revolutions", 0, int'(status.revolutions));

		send_pulse(quiet_gap, 1, 1'b1);
		check_status("pulse 1");
		send_pulse(quiet_gap, 3, 1'b1);
		check_status("pulse 3");
		send_pulse(quiet_gap, 8, 1'b1);
		check_status("pulse 8");
		send_pulse(quiet_gap, 20, 1'b1);
		check_status("pulse 20");

		// second glitch lands 4 samples after the first
		repeat (3) begin
			send_pulse(quiet_gap, 1, 1'b1);
			send_pulse(3, 1, 1'b0);
			check_status("glitch pair");
		end

		repeat (random_markers) begin
			gap = 20 + ($random(seed) & 31);
			len = 1 + ($random(seed) & 7);
			send_pulse(gap, len, 1'b1);
			check_status("random marker");
		end

		sva_failures = revo_encoder_top_inst.revo_encoder_sva_inst.failures;
		$display("value errors: %0d, assertion failures: %0d", value_errors, sva_failures);
		if (value_errors == 0 && sva_failures == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- revo_encoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module revo_encoder_top (
	input logic clock254,
	input logic reset,
	input logic raw_revo,
	output revo_pkg::revo_lines_t lines,
	output revo_pkg::revo_status_t status,
	output logic [7:0] leds
);

	logic marker;
	logic ready;

	// glitch and spacing filter on the raw input
	revo_qualifier revo_qualifier_inst (
		.clock254(clock254),
		.reset(reset),
		.raw_revo(raw_revo),
		.marker(marker)
	);

	revo_line_encoder revo_line_encoder_inst (
		.clock254(clock254),
		.reset(reset),
		.marker(marker),
		.lines(lines),
		.ready(ready)
	);

	// local copy of what the far end recovers
	revo_line_monitor revo_line_monitor_inst (
		.clock254(clock254),
		.reset(reset),
		.lines(lines),
		.ready(ready),
		.status(status),
		.leds(leds)
	);

endmodule

`default_nettype wire

//--- revo_line_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module revo_line_encoder (
	input logic clock254,
	input logic reset,
	input logic marker,
	output revo_pkg::revo_lines_t lines,
	output logic ready
);

	revo_pkg::encoder_state_t state;
	logic [revo_pkg::hold_width-1:0] hold_count;
	logic armed;
	logic line_marker;

	// hold after reset, then run for good
	always_ff @(posedge clock254) begin
		if (reset) begin
			state <= revo_pkg::st_hold;
			hold_count <= '0;
			ready <= 1'b0;
		end else begin
			case (state)
				revo_pkg::st_hold: begin
					hold_count <= hold_count + 1'b1;
					if (hold_count == revo_pkg::hold_last) begin
						state <= revo_pkg::st_run;
						ready <= 1'b1;
					end
				end
				revo_pkg::st_run: begin
					ready <= 1'b1;
				end
				default: begin
					state <= revo_pkg::st_hold;
					ready <= 1'b0;
				end
			endcase
		end
	end

	// a marker still high when the hold ends is not put on the line,
	// the encoder waits for it to drop first
	always_ff @(posedge clock254) begin
		if (reset) begin
			armed <= 1'b0;
		end else if (state == revo_pkg::st_run) begin
			if (!marker) begin
				armed <= 1'b1;
			end
		end else begin
			armed <= ~marker;
		end
	end

	assign line_marker = marker & armed;

	// ref line is the 127 MHz line clock as a toggle.
	// marked line skips one toggle when the marker rises and one when it
	// falls, so ref ^ marked equals the marker one edge later
	always_ff @(posedge clock254) begin
		if (reset) begin
			lines.ref_line <= 1'b0;
			lines.marked_line <= 1'b0;
		end else if (state == revo_pkg::st_run) begin
			lines.ref_line <= ~lines.ref_line;
			lines.marked_line <= ~lines.ref_line ^ line_marker;
		end else begin
			// lines quiet during the hold
			lines.ref_line <= 1'b0;
			lines.marked_line <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- revo_line_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module revo_line_monitor (
	input logic clock254,
	input logic reset,
	input revo_pkg::revo_lines_t lines,
	input logic ready,
	output revo_pkg::revo_status_t status,
	output logic [7:0] leds
);

	revo_pkg::monitor_state_t state;
	logic recovered;
	logic recovered_d;
	logic rise;
	logic [revo_pkg::count_width-1:0] period_count;
	logic [revo_pkg::count_width-1:0] revolutions;
	logic [revo_pkg::count_width-1:0] last_period;

	// receiver side: marker is the xor of the pair
	always_ff @(posedge clock254) begin
		if (reset) begin
			recovered <= 1'b0;
			recovered_d <= 1'b0;
		end else begin
			recovered <= lines.ref_line ^ lines.marked_line;
			recovered_d <= recovered;
		end
	end

	assign rise = recovered & ~recovered_d;

	// restarts at 1 on each marker so the next capture is the edge distance
	always_ff @(posedge clock254) begin
		if (reset) begin
			period_count <= '0;
		end else if (rise) begin
			period_count <= 1;
		end else begin
			period_count <= period_count + 1'b1;
		end
	end

	always_ff @(posedge clock254) begin
		if (reset) begin
			revolutions <= '0;
		end else if (rise) begin
			revolutions <= revolutions + 1'b1;
		end
	end

	// first marker only starts the period measurement
	always_ff @(posedge clock254) begin
		if (reset) begin
			state <= revo_pkg::st_wait_first;
			last_period <= '0;
		end else begin
			case (state)
				revo_pkg::st_wait_first: begin
					if (rise) begin
						state <= revo_pkg::st_measure;
					end
				end
				revo_pkg::st_measure: begin
					if (rise) begin
						last_period <= period_count;
					end
				end
				default: begin
					state <= revo_pkg::st_wait_first;
				end
			endcase
		end
	end

	always_comb begin
		status.ready = ready;
		status.marker = recovered;
		status.revolutions = revolutions;
		status.last_period = last_period;
	end

	// front panel, unused positions stay dark
	always_ff @(posedge clock254) begin
		if (reset) begin
			leds <= '0;
		end else begin
			leds <= '0;
			leds[revo_pkg::led_not_ready] <= ~ready;
			leds[revo_pkg::led_marker] <= recovered;
			leds[revo_pkg::led_revo_lsb] <= revolutions[0];
			leds[revo_pkg::led_ready] <= ready;
		end
	end

endmodule

`default_nettype wire

//--- revo_pkg.sv
`default_nettype none

package revo_pkg;

	// raw revolution input history, split into an older and a newer half
	localparam int history_width = 16;
	localparam int quiet_samples = 8;
	localparam int older_width = history_width - quiet_samples;

	// startup hold, stands in for the pll lock wait
	localparam int hold_cycles = 1024;
	localparam int hold_width = $clog2(hold_cycles);
	localparam logic [hold_width-1:0] hold_last = hold_width'(hold_cycles - 1);

	// revolution and period counters
	localparam int count_width = 16;

	// status led positions
	localparam int led_count = 8;
	localparam int led_not_ready = 7;
	localparam int led_marker = 4;
	localparam int led_revo_lsb = 2;
	localparam int led_ready = 0;

	typedef enum logic {
		st_hold,
		st_run
	} encoder_state_t;

	typedef enum logic {
		st_wait_first,
		st_measure
	} monitor_state_t;

	// reference clock line and the line carrying the marker
	typedef struct packed {
		logic ref_line;
		logic marked_line;
	} revo_lines_t;

	typedef struct packed {
		logic ready;
		logic marker;
		logic [count_width-1:0] revolutions;
		logic [count_width-1:0] last_period;
	} revo_status_t;

endpackage

`default_nettype wire

//--- revo_qualifier.sv
`timescale 1ns/1ps
`default_nettype none

module revo_qualifier (
	input logic clock254,
	input logic reset,
	input logic raw_revo,
	output logic marker
);

	logic [revo_pkg::history_width-1:0] history;
	logic [revo_pkg::older_width-1:0] older;
	logic [revo_pkg::quiet_samples-1:0] newer;
	logic older_quiet;
	logic newer_active;

	// newest sample enters at bit 0
	always_ff @(posedge clock254) begin
		if (reset) begin
			history <= '0;
		end else begin
			history <= {history[revo_pkg::history_width-2:0], raw_revo};
		end
	end

	// both halves registered, then compared one cycle later
	always_ff @(posedge clock254) begin
		if (reset) begin
			older <= '0;
			newer <= '0;
		end else begin
			older <= history[revo_pkg::history_width-1:revo_pkg::quiet_samples];
			newer <= history[revo_pkg::quiet_samples-1:0];
		end
	end

	assign older_quiet = (older == '0);
	assign newer_active = (newer != '0);

	// high while the edge walks through the newer half, so exactly
	// quiet_samples cycles whatever the pulse length
	always_ff @(posedge clock254) begin
		if (reset) begin
			marker <= 1'b0;
		end else begin
			marker <= older_quiet & newer_active;
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the revolution encoder testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Mdir obj_dir \
	--top-module revo_encoder_tb -f sources.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# keep running past assertion errors so the closing report is printed
output=$(./obj_dir/Vrevo_encoder_tb +verilator+error+limit+1000)
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- sources.f
revo_pkg.sv
revo_qualifier.sv
revo_line_encoder.sv
revo_line_monitor.sv
revo_encoder_top.sv
revo_encoder_sva.sv
revo_encoder_tb.sv
